// File: logic/displayPkg.sv
package displayPkg;

    //////////////////////////////////////////////////////////////////////
    // scan geometry
    //////////////////////////////////////////////////////////////////////

    // scan counter width
    localparam int coordWidth = 10;

    // one spare bit so origin plus offset plus size stays in range
    localparam int boundWidth = coordWidth + 1;

    // visible window, both ends inclusive
    localparam int hOrigin = 144;
    localparam int vOrigin = 35;
    localparam int hLast = 784;
    localparam int vLast = 515;

    // frame drawn inside the window edges
    localparam int borderThick = 8;

    // walls and scrolls per scene
    localparam int objCount = 8;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef logic [3:0] colorT;
    typedef logic [coordWidth-1:0] coordT;
    typedef logic [boundWidth-1:0] boundT;

    localparam colorT borderColor = 4'd6;
    localparam colorT backColor = 4'd0;

    // current pixel from the scan counters
    typedef struct packed {
        coordT hCount;
        coordT vCount;
    } pixelPosT;

    // one rectangle on screen, positions relative to the window origin
    typedef struct packed {
        logic visible;
        coordT hStart;
        coordT vStart;
        coordT hOffset;
        coordT vOffset;
        coordT width;
        coordT height;
        colorT color;
    } spriteT;

    // result of one layer search
    typedef struct packed {
        logic hit;
        colorT color;
    } layerHitT;

    //////////////////////////////////////////////////////////////////////
    // rectangle test
    //////////////////////////////////////////////////////////////////////

    // inclusive on all four edges, visible bit is left to the caller
    function automatic logic spriteCovers(input spriteT s, input pixelPosT p);
        boundT left;
        boundT right;
        boundT top;
        boundT bottom;
        logic inH;
        logic inV;
        left = boundT'(s.hStart) + boundT'(hOrigin) + boundT'(s.hOffset);
        right = left + boundT'(s.width);
        top = boundT'(s.vStart) + boundT'(vOrigin) + boundT'(s.vOffset);
        bottom = top + boundT'(s.height);
        inH = (boundT'(p.hCount) >= left) && (boundT'(p.hCount) <= right);
        inV = (boundT'(p.vCount) >= top) && (boundT'(p.vCount) <= bottom);
        return inH && inV;
    endfunction

endpackage

// File: logic/pixelCompositor.sv
`timescale 1ns/1ps

module pixelCompositor
    import displayPkg::*;
(
    input logic clk,
    input logic rstN,
    input pixelPosT pixel,
    input layerHitT playerHit,
    input layerHitT wallHit,
    input layerHitT scrollHit,
    output colorT colorSel
);

    //////////////////////////////////////////////////////////////////////
    // window and border
    //////////////////////////////////////////////////////////////////////

    logic inWindow;
    logic hBorder;
    logic vBorder;
    logic onBorder;
    colorT nextColor;

    // inside the visible area, edges included
    assign inWindow = (pixel.hCount >= hOrigin) && (pixel.hCount <= hLast)
                   && (pixel.vCount >= vOrigin) && (pixel.vCount <= vLast);

    // borderThick columns at the left and right edge
    assign hBorder = (pixel.hCount < hOrigin + borderThick)
                  || (pixel.hCount > hLast - borderThick);

    // same for the top and bottom rows
    assign vBorder = (pixel.vCount < vOrigin + borderThick)
                  || (pixel.vCount > vLast - borderThick);

    // only meaningful inside the window
    assign onBorder = hBorder || vBorder;

    //////////////////////////////////////////////////////////////////////
    // layer priority
    //////////////////////////////////////////////////////////////////////

    always_comb
    begin
        if (!inWindow)
        begin
            // blanking
            nextColor = backColor;
        end
        else if (onBorder)
        begin
            nextColor = borderColor;
        end
        else if (playerHit.hit)
        begin
            nextColor = playerHit.color;
        end
        else if (wallHit.hit)
        begin
            nextColor = wallHit.color;
        end
        else if (scrollHit.hit)
        begin
            nextColor = scrollHit.color;
        end
        else
        begin
            // empty floor
            nextColor = backColor;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////////////////////////

    // one cycle from pixel to colour
    always_ff @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            colorSel <= backColor;
        end
        else
        begin
            colorSel <= nextColor;
        end
    end

endmodule

// File: logic/sceneRenderer.sv
`timescale 1ns/1ps

module sceneRenderer
    import displayPkg::*;
(
    input logic clk,
    input logic rstN,
    input pixelPosT pixel,
    input spriteT player,
    input spriteT [objCount-1:0] walls,
    input spriteT [objCount-1:0] scrolls,
    output colorT colorSel
);

    //////////////////////////////////////////////////////////////////////
    // layer searches
    //////////////////////////////////////////////////////////////////////

    layerHitT playerHit;
    layerHitT wallHit;
    layerHitT scrollHit;

    // player list of one, always shown
    spriteT [0:0] playerList;

    always_comb
    begin
        playerList[0] = player;
        playerList[0].visible = 1'b1;
    end

    spriteLayer #(
        .count(1)
    ) playerLayer (
        .pixel(pixel),
        .objs(playerList),
        .hit(playerHit)
    );

    spriteLayer #(
        .count(objCount)
    ) wallLayer (
        .pixel(pixel),
        .objs(walls),
        .hit(wallHit)
    );

    spriteLayer #(
        .count(objCount)
    ) scrollLayer (
        .pixel(pixel),
        .objs(scrolls),
        .hit(scrollHit)
    );

    //////////////////////////////////////////////////////////////////////
    // final colour
    //////////////////////////////////////////////////////////////////////

    // registered here, the layers are combinational
    pixelCompositor compositor (
        .clk(clk),
        .rstN(rstN),
        .pixel(pixel),
        .playerHit(playerHit),
        .wallHit(wallHit),
        .scrollHit(scrollHit),
        .colorSel(colorSel)
    );

endmodule

// File: logic/spriteLayer.sv
`timescale 1ns/1ps

module spriteLayer
    import displayPkg::*;
#(
    parameter int count = 1
)
(
    input pixelPosT pixel,
    input spriteT [count-1:0] objs,
    output layerHitT hit
);

    //////////////////////////////////////////////////////////////////////
    // per object hit test
    //////////////////////////////////////////////////////////////////////

    // one bit per sprite, already gated by visibility
    logic [count-1:0] covers;

    genvar i;
    generate
        for (i = 0; i < count; i++)
        begin : gCover
            assign covers[i] = objs[i].visible && spriteCovers(objs[i], pixel);
        end
    endgenerate

    //////////////////////////////////////////////////////////////////////
    // first hit search
    //////////////////////////////////////////////////////////////////////

    // lowest index wins, later hits are ignored
    always_comb
    begin
        hit.hit = 1'b0;
        hit.color = backColor;
        for (int k = 0; k < count; k++)
        begin
            if (covers[k] && !hit.hit)
            begin
                hit.hit = 1'b1;
                hit.color = objs[k].color;
            end
        end
    end

endmodule

// File: run.sh
#!/usr/bin/env bash
# build the scene renderer testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --assert --top-module sceneRendererTb -f tb.f -o simv \
    && ./obj_dir/simv | tee sim.log \
    || { echo "build or simulation did not complete"; exit 1; }
grep -q "TEST PASSED" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: tb.f
logic/displayPkg.sv
logic/spriteLayer.sv
logic/pixelCompositor.sv
logic/sceneRenderer.sv
tests/sceneChecker.sv
tests/sceneRenderer_asserts.sv
tests/sceneRendererTb.sv

// File: tests/sceneChecker.sv
`timescale 1ns/1ps

module sceneChecker
    import displayPkg::*;
(
    input logic clk,
    input logic rstN,
    input pixelPosT pixel,
    input logic expValid,
    input colorT expColor,
    input colorT colorSel,
    output int mismatches,
    output int checks
);

    //////////////////////////////////////////////////////////////////////
    // expectation pipeline
    //////////////////////////////////////////////////////////////////////

    // probe that the DUT registered on the last edge
    logic heldValid;
    colorT heldColor;
    pixelPosT heldPixel;

    // colorSel is read before it moves on at this edge
    always @(posedge clk or negedge rstN)
    begin
        if (!rstN)
        begin
            heldValid <= 1'b0;
            heldColor <= backColor;
            heldPixel <= '0;
            mismatches <= 0;
            checks <= 0;
        end
        else
        begin
            if (heldValid)
            begin
                checks <= checks + 1;
                if (colorSel !== heldColor)
                begin
                    $display("FAIL at %0d ns: colorSel expected %0d, got %0d (pixel %0d,%0d)",
                             $time, heldColor, colorSel, heldPixel.hCount, heldPixel.vCount);
                    mismatches <= mismatches + 1;
                end
            end
            heldValid <= expValid;
            heldColor <= expColor;
            heldPixel <= pixel;
        end
    end

endmodule

// File: tests/sceneRendererTb.sv
`timescale 1ns/1ps

module sceneRendererTb
    import displayPkg::*;
();

    //////////////////////////////////////////////////////////////////////
    // DUT, checker and bound assertions
    //////////////////////////////////////////////////////////////////////

    logic clk;
    logic rstN;
    pixelPosT pixel;
    spriteT player;
    spriteT [objCount-1:0] walls;
    spriteT [objCount-1:0] scrolls;
    colorT colorSel;
    logic expValid;
    colorT expColor;
    int mismatches;
    int checks;

    // scene as built up from the file, handed to the DUT with the next probe
    spriteT pendPlayer;
    spriteT [objCount-1:0] pendWalls;
    spriteT [objCount-1:0] pendScrolls;

    string testLines[$];
    int probeTotal;
    int otherErrors;
    logic loaded;

    sceneRenderer i_sceneRenderer (
        .clk(clk),
        .rstN(rstN),
        .pixel(pixel),
        .player(player),
        .walls(walls),
        .scrolls(scrolls),
        .colorSel(colorSel)
    );

    sceneChecker colorCheck (
        .clk(clk),
        .rstN(rstN),
        .pixel(pixel),
        .expValid(expValid),
        .expColor(expColor),
        .colorSel(colorSel),
        .mismatches(mismatches),
        .checks(checks)
    );

    bind sceneRenderer sceneRendererAsserts i_sceneRendererAsserts (
        .clk(clk),
        .rstN(rstN),
        .pixel(pixel),
        .colorSel(colorSel)
    );

    //////////////////////////////////////////////////////////////////////
    // test file handling
    //////////////////////////////////////////////////////////////////////

    // whole file into memory, probes counted for the watchdog
    task automatic loadTests();
        int fd;
        string line;
        string kind;
        fd = $fopen("tests/sceneTests.txt", "r");
        if (fd == 0)
        begin
            $display("could not open tests/sceneTests.txt");
            otherErrors++;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            testLines.push_back(line);
            if ($sscanf(line, "%s", kind) == 1 && kind == "probe")
                probeTotal++;
        end
        $fclose(fd);
    endtask

    // scene line, only the pending copy changes
    task automatic applyScene(input string line);
        string kind;
        int idx, vis, hs, vs, ho, vo, w, h, c;
        spriteT s;
        if ($sscanf(line, "%s %d %d %d %d %d %d %d %d %d",
                    kind, idx, vis, hs, vs, ho, vo, w, h, c) != 10)
        begin
            $display("scene line could not be read: %s", line);
            otherErrors++;
            return;
        end
        s.visible = vis[0];
        s.hStart = coordT'(hs);
        s.vStart = coordT'(vs);
        s.hOffset = coordT'(ho);
        s.vOffset = coordT'(vo);
        s.width = coordT'(w);
        s.height = coordT'(h);
        s.color = colorT'(c);
        if (kind == "player")
            pendPlayer = s;
        else if (kind == "wall" && idx >= 0 && idx < objCount)
            pendWalls[idx] = s;
        else if (kind == "scroll" && idx >= 0 && idx < objCount)
            pendScrolls[idx] = s;
        else
        begin
            $display("scene line names an unknown layer or index: %s", line);
            otherErrors++;
        end
    endtask

    // one probe per rising edge
    task automatic driveProbe(input string line);
        string kind;
        int col, row, want;
        if ($sscanf(line, "%s %d %d %d", kind, col, row, want) != 4)
        begin
            $display("probe line could not be read: %s", line);
            otherErrors++;
            return;
        end
        @(posedge clk);
        player <= pendPlayer;
        walls <= pendWalls;
        scrolls <= pendScrolls;
        pixel.hCount <= coordT'(col);
        pixel.vCount <= coordT'(row);
        expValid <= 1'b1;
        expColor <= colorT'(want);
    endtask

    task automatic playLine(input string line);
        string kind;
        if (line.getc(0) == "#" || $sscanf(line, "%s", kind) != 1)
            return;
        if (kind == "probe")
            driveProbe(line);
        else
            applyScene(line);
    endtask

    //////////////////////////////////////////////////////////////////////
    // clock, sequence and watchdog
    //////////////////////////////////////////////////////////////////////

    initial
    begin
        clk = 1'b0;
        forever
        begin
            #50 clk = ~clk;
        end
    end

    initial
    begin : mainFlow
        rstN = 1'b0;
        pixel = '0;
        player = '0;
        walls = '0;
        scrolls = '0;
        expValid = 1'b0;
        expColor = backColor;
        pendPlayer = '0;
        pendWalls = '0;
        pendScrolls = '0;
        probeTotal = 0;
        otherErrors = 0;
        loaded = 1'b0;
        loadTests();
        loaded = 1'b1;
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        foreach (testLines[i])
            playLine(testLines[i]);
        @(posedge clk);
        expValid <= 1'b0;
        // last result needs two more edges to reach the checker
        repeat (3) @(posedge clk);
        if (checks != probeTotal)
        begin
            $display("only %0d of %0d probes were checked", checks, probeTotal);
            otherErrors++;
        end
        $display("errors: %0d colour mismatches, %0d other errors, %0d probes checked",
                 mismatches, otherErrors, checks);
        if (mismatches == 0 && otherErrors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    // reset, every probe and some slack
    initial
    begin : watchdog
        wait (loaded);
        #((probeTotal + 20) * 100);
        $display("timeout: the run did not end within %0d clock cycles", probeTotal + 20);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// File: tests/sceneRenderer_asserts.sv
`timescale 1ns/1ps

module sceneRendererAsserts
    import displayPkg::*;
(
    input logic clk,
    input logic rstN,
    input pixelPosT pixel,
    input colorT colorSel
);

    // pixel in the blanking area
    logic outside;

    assign outside = (pixel.hCount < coordT'(hOrigin)) || (pixel.hCount > coordT'(hLast))
                  || (pixel.vCount < coordT'(vOrigin)) || (pixel.vCount > coordT'(vLast));

    //////////////////////////////////////////////////////////////////////
    // properties
    //////////////////////////////////////////////////////////////////////

    resetHoldsBack: assert property (@(posedge clk) !rstN |-> colorSel == backColor)
        else $error("colorSel left the background colour during reset");

    // blanking shows one cycle later
    blankingIsBack: assert property (
        @(posedge clk) disable iff (!rstN) outside |=> colorSel == backColor)
        else $error("colorSel not background after an out-of-window pixel");

    colorKnown: assert property (@(posedge clk) disable iff (!rstN) !$isunknown(colorSel))
        else $error("colorSel is unknown after reset");

endmodule

// File: tests/sceneTests.txt
# scene: layer index visible hStart vStart hOffset vOffset width height color
# probe: probe column row expectedColor (all decimal)
player 0 1 100 100 0 0 20 20 9
wall 0 1 90 90 0 0 60 60 3
wall 1 1 80 80 0 0 100 100 4
wall 2 1 300 200 10 20 10 10 7
wall 3 1 0 0 0 0 40 40 2
wall 4 1 620 400 0 0 40 40 11
wall 5 1 300 460 0 0 20 40 12
scroll 0 1 70 70 0 0 150 150 5
scroll 1 1 500 100 0 0 30 30 13
probe 0 0 0
probe 143 200 0
probe 785 200 0
probe 400 34 0
probe 400 516 0
probe 144 200 6
probe 151 200 6
probe 152 200 0
probe 784 200 6
probe 777 200 6
probe 776 200 0
probe 400 35 6
probe 400 42 6
probe 400 43 0
probe 400 515 6
probe 400 508 6
probe 400 507 0
probe 148 60 6
probe 160 38 6
probe 160 60 2
probe 780 450 6
probe 770 450 11
probe 790 450 0
probe 450 510 6
probe 450 500 12
probe 450 520 0
probe 250 140 9
probe 244 145 9
probe 243 145 3
probe 264 145 9
probe 265 145 3
probe 250 135 9
probe 250 134 3
probe 290 130 3
probe 230 120 4
probe 300 150 4
probe 330 150 5
probe 220 110 5
probe 650 140 13
probe 454 255 7
probe 464 265 7
probe 453 255 0
probe 454 254 0
probe 444 235 0
wall 0 0 90 90 0 0 60 60 3
probe 290 130 4
probe 250 140 9
wall 1 0 80 80 0 0 100 100 4
probe 300 150 5
probe 230 120 5
scroll 0 0 70 70 0 0 150 150 5
probe 230 120 0
wall 2 0 300 200 10 20 10 10 7
probe 454 255 0
player 0 0 100 100 0 0 20 20 9
probe 250 140 9
probe 243 145 0
